// ==== hdl/respq_config.svh ====
/*
  response queue configuration macros
  queue depth, entry id width, responder count
*/
`ifndef RESPQ_CONFIG_SVH
`define RESPQ_CONFIG_SVH

// number of queue entries, 2 to 16
`define RESPQ_DEPTH 8

// entry id width, must cover RESPQ_DEPTH
`define RESPQ_ID_W 3

// responders: l2, ebiu, piu3..piu0
// fixed by the named response ports
`define RESPQ_SRC_NUM 6

`endif

// ==== hdl/respq_ctrl.sv ====
/*
  response queue allocation control
  busy mask, lowest free index, create handshake,
  per-entry create strobes, outstanding count
*/
`timescale 1ns/1ps
`default_nettype none
`include "respq_config.svh"

module respq_ctrl (
  input  logic                   respqentyclk,
  input  logic                   cpurst_b,
  input  logic                   create_vld,
  input  respq_pkg::entry_mask_t entry_vld,
  input  respq_pkg::entry_mask_t retire_pend,
  output logic                   create_rdy,
  output respq_pkg::entry_id_t   create_id,
  output respq_pkg::entry_mask_t entry_create_en
);

  // wide enough to hold the full depth
  localparam int CNT_W = `RESPQ_ID_W + 1;

  respq_pkg::entry_mask_t busy;
  respq_pkg::entry_mask_t busy_snap_q;
  respq_pkg::entry_mask_t freed;
  logic [CNT_W-1:0]       cnt_q;
  logic [CNT_W-1:0]       free_cnt;
  logic [CNT_W-1:0]       cnt_cur;
  logic                   create_fire;

  // busy while valid or still waiting to retire
  assign busy = entry_vld | retire_pend;

  //==================================================
  // lowest free index
  //==================================================

  // scan high to low so the lowest free index wins
  always_comb
  begin
    create_id = '0;
    for (int i = `RESPQ_DEPTH - 1; i >= 0; i--)
    begin
      if (!busy[i])
      begin
        create_id = respq_pkg::entry_id_t'(i);
      end
    end
  end

  //==================================================
  // outstanding count
  //==================================================

  // entries busy at the last edge that have since retired
  assign freed = busy_snap_q & ~busy;

  always_comb
  begin
    free_cnt = '0;
    for (int i = 0; i < `RESPQ_DEPTH; i++)
    begin
      free_cnt = free_cnt + CNT_W'(freed[i]);
    end
  end

  // count of entries busy right now
  assign cnt_cur = cnt_q - free_cnt;

  // full flag from the count
  assign create_rdy  = (cnt_cur != CNT_W'(`RESPQ_DEPTH));
  assign create_fire = create_vld & create_rdy;

  // single strobe to the chosen entry
  assign entry_create_en = create_fire ?
                           (respq_pkg::entry_mask_t'(1) << create_id) : '0;

  always_ff @(posedge respqentyclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cnt_q       <= '0;
      busy_snap_q <= '0;
    end
    else
    begin
      cnt_q       <= cnt_cur + CNT_W'(create_fire);
      busy_snap_q <= busy | entry_create_en;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/respq_entry.sv ====
/*
  single response queue entry
  valid flag, dvm flag, six completion bits
  self pop once every responder has completed
*/
`timescale 1ns/1ps
`default_nettype none

module respq_entry (
  input  logic                 respqentyclk,
  input  logic                 cpurst_b,
  input  logic                 create_en,
  input  logic                 create_dvm,
  input  respq_pkg::src_mask_t create_cmplt_init,
  input  respq_pkg::src_mask_t resp_en,
  output logic                 vld,
  output logic                 dvm,
  output logic                 pop
);

  //==================================================
  // entry content
  //   vld   : operation outstanding
  //   dvm   : dvm operation
  //   cmplt : [5] l2, [4] ebiu, [3:0] piu3..piu0
  //==================================================

  logic                 vld_q;
  logic                 dvm_q;
  respq_pkg::src_mask_t cmplt_q;
  respq_pkg::src_mask_t cmplt_nxt;
  logic                 all_cmplt;

  // every responder done
  assign all_cmplt = &cmplt_q;

  // pop only while valid, clears valid next edge
  assign pop = vld_q & all_cmplt;

  //==================================================
  // valid flag
  //==================================================

  always_ff @(posedge respqentyclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      vld_q <= 1'b0;
    end
    else if (create_en)
    begin
      vld_q <= 1'b1;
    end
    else if (pop)
    begin
      vld_q <= 1'b0;
    end
  end

  //==================================================
  // completion bits
  //==================================================

  // create reloads the mask and wins over responses
  // a response only ever sets its own bit
  always_comb
  begin
    if (create_en)
    begin
      cmplt_nxt = create_cmplt_init;
    end
    else
    begin
      cmplt_nxt = cmplt_q | resp_en;
    end
  end

  always_ff @(posedge respqentyclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cmplt_q <= '0;
    end
    else
    begin
      cmplt_q <= cmplt_nxt;
    end
  end

  //==================================================
  // dvm flag
  //==================================================

  // loaded at create, held until the next create
  always_ff @(posedge respqentyclk)
  begin
    if (create_en)
    begin
      dvm_q <= create_dvm;
    end
  end

  // outputs
  assign vld = vld_q;
  assign dvm = dvm_q;

endmodule

`default_nettype wire

// ==== hdl/respq_pkg.sv ====
/*
  response queue shared types
  entry id, entry mask, responder mask
  and responder bit positions
*/
`default_nettype none
`include "respq_config.svh"

package respq_pkg;

  // index of one queue entry
  typedef logic [`RESPQ_ID_W-1:0] entry_id_t;

  // one bit per entry: busy, valid, pop, pending
  typedef logic [`RESPQ_DEPTH-1:0] entry_mask_t;

  // one bit per responder, set means nothing owed
  typedef logic [`RESPQ_SRC_NUM-1:0] src_mask_t;

  // responder bit positions in src_mask_t
  localparam int SRC_L2C  = 5;
  localparam int SRC_EBIU = 4;
  localparam int SRC_PIU3 = 3;
  localparam int SRC_PIU2 = 2;
  localparam int SRC_PIU1 = 1;
  localparam int SRC_PIU0 = 0;

endpackage

`default_nettype wire

// ==== hdl/respq_resp_decode.sv ====
/*
  response pulse decoder
  six responder valid/id pairs in,
  one six-bit completion strobe per entry out
*/
`timescale 1ns/1ps
`default_nettype none
`include "respq_config.svh"

module respq_resp_decode (
  input  logic                 l2c_resp_vld,
  input  respq_pkg::entry_id_t l2c_resp_id,
  input  logic                 ebiu_resp_vld,
  input  respq_pkg::entry_id_t ebiu_resp_id,
  input  logic                 piu3_resp_vld,
  input  respq_pkg::entry_id_t piu3_resp_id,
  input  logic                 piu2_resp_vld,
  input  respq_pkg::entry_id_t piu2_resp_id,
  input  logic                 piu1_resp_vld,
  input  respq_pkg::entry_id_t piu1_resp_id,
  input  logic                 piu0_resp_vld,
  input  respq_pkg::entry_id_t piu0_resp_id,
  output respq_pkg::src_mask_t entry_resp_en [`RESPQ_DEPTH]
);

  //==================================================
  // gather responders into mask order
  //==================================================

  respq_pkg::src_mask_t src_vld;
  respq_pkg::entry_id_t src_id [`RESPQ_SRC_NUM];

  assign src_vld[respq_pkg::SRC_L2C]  = l2c_resp_vld;
  assign src_vld[respq_pkg::SRC_EBIU] = ebiu_resp_vld;
  assign src_vld[respq_pkg::SRC_PIU3] = piu3_resp_vld;
  assign src_vld[respq_pkg::SRC_PIU2] = piu2_resp_vld;
  assign src_vld[respq_pkg::SRC_PIU1] = piu1_resp_vld;
  assign src_vld[respq_pkg::SRC_PIU0] = piu0_resp_vld;

  assign src_id[respq_pkg::SRC_L2C]   = l2c_resp_id;
  assign src_id[respq_pkg::SRC_EBIU]  = ebiu_resp_id;
  assign src_id[respq_pkg::SRC_PIU3]  = piu3_resp_id;
  assign src_id[respq_pkg::SRC_PIU2]  = piu2_resp_id;
  assign src_id[respq_pkg::SRC_PIU1]  = piu1_resp_id;
  assign src_id[respq_pkg::SRC_PIU0]  = piu0_resp_id;

  //==================================================
  // one-hot decode, transposed per entry
  //==================================================

  // bit s of entry e: responder s answered entry e
  for (genvar e = 0; e < `RESPQ_DEPTH; e++)
  begin : g_entry
    for (genvar s = 0; s < `RESPQ_SRC_NUM; s++)
    begin : g_src
      assign entry_resp_en[e][s] = src_vld[s] &&
                                   (src_id[s] == respq_pkg::entry_id_t'(e));
    end
  end

endmodule

`default_nettype wire

// ==== hdl/respq_retire_arb.sv ====
/*
  response queue retire stage
  pending mask, dvm capture at pop,
  lowest-index select held under back-pressure
*/
`timescale 1ns/1ps
`default_nettype none
`include "respq_config.svh"

module respq_retire_arb (
  input  logic                   respqentyclk,
  input  logic                   cpurst_b,
  input  respq_pkg::entry_mask_t entry_pop,
  input  respq_pkg::entry_mask_t entry_dvm,
  input  logic                   retire_rdy,
  output respq_pkg::entry_mask_t retire_pend,
  output logic                   retire_vld,
  output respq_pkg::entry_id_t   retire_id,
  output logic                   retire_dvm
);

  respq_pkg::entry_mask_t pend_q;
  respq_pkg::entry_mask_t dvm_q;
  respq_pkg::entry_mask_t retire_clr;
  respq_pkg::entry_id_t   lowest_id;
  respq_pkg::entry_id_t   hold_id_q;
  logic                   hold_q;
  logic                   stall;

  //==================================================
  // entry select
  //==================================================

  // lowest pending entry
  always_comb
  begin
    lowest_id = '0;
    for (int i = `RESPQ_DEPTH - 1; i >= 0; i--)
    begin
      if (pend_q[i])
      begin
        lowest_id = respq_pkg::entry_id_t'(i);
      end
    end
  end

  assign retire_vld = |pend_q;
  // stalled entry keeps its slot even if a lower one pops
  assign retire_id  = hold_q ? hold_id_q : lowest_id;
  assign retire_dvm = dvm_q[retire_id];
  assign stall      = retire_vld & ~retire_rdy;

  // handshake clears the presented entry
  assign retire_clr = (retire_vld & retire_rdy) ?
                      (respq_pkg::entry_mask_t'(1) << retire_id) : '0;

  //==================================================
  // pending and dvm state
  //==================================================

  always_ff @(posedge respqentyclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pend_q    <= '0;
      dvm_q     <= '0;
      hold_q    <= 1'b0;
      hold_id_q <= '0;
    end
    else
    begin
      pend_q    <= (pend_q & ~retire_clr) | entry_pop;
      // dvm captured as the entry pops
      dvm_q     <= (dvm_q & ~entry_pop) | (entry_dvm & entry_pop);
      hold_q    <= stall;
      hold_id_q <= retire_id;
    end
  end

  assign retire_pend = pend_q;

endmodule

`default_nettype wire

// ==== hdl/respq_top.sv ====
/*
  response queue top level
  control, response decoder, retire stage
  and the array of queue entries
*/
`timescale 1ns/1ps
`default_nettype none
`include "respq_config.svh"

module respq_top (
  input  logic                 respqentyclk,
  input  logic                 cpurst_b,
  // create handshake
  input  logic                 create_vld,
  input  logic                 create_dvm,
  input  respq_pkg::src_mask_t create_cmplt_init,
  output logic                 create_rdy,
  output respq_pkg::entry_id_t create_id,
  // responder pulses
  input  logic                 l2c_resp_vld,
  input  respq_pkg::entry_id_t l2c_resp_id,
  input  logic                 ebiu_resp_vld,
  input  respq_pkg::entry_id_t ebiu_resp_id,
  input  logic                 piu3_resp_vld,
  input  respq_pkg::entry_id_t piu3_resp_id,
  input  logic                 piu2_resp_vld,
  input  respq_pkg::entry_id_t piu2_resp_id,
  input  logic                 piu1_resp_vld,
  input  respq_pkg::entry_id_t piu1_resp_id,
  input  logic                 piu0_resp_vld,
  input  respq_pkg::entry_id_t piu0_resp_id,
  // retire handshake
  input  logic                 retire_rdy,
  output logic                 retire_vld,
  output respq_pkg::entry_id_t retire_id,
  output logic                 retire_dvm
);

  respq_pkg::entry_mask_t entry_vld;
  respq_pkg::entry_mask_t entry_dvm;
  respq_pkg::entry_mask_t entry_pop;
  respq_pkg::entry_mask_t entry_create_en;
  respq_pkg::entry_mask_t retire_pend;
  respq_pkg::src_mask_t   entry_resp_en [`RESPQ_DEPTH];

  //==================================================
  // allocation
  //==================================================

  respq_ctrl u_ctrl (
    .respqentyclk    (respqentyclk),
    .cpurst_b        (cpurst_b),
    .create_vld      (create_vld),
    .entry_vld       (entry_vld),
    .retire_pend     (retire_pend),
    .create_rdy      (create_rdy),
    .create_id       (create_id),
    .entry_create_en (entry_create_en)
  );

  // responses, always accepted
  respq_resp_decode u_resp_decode (
    .l2c_resp_vld  (l2c_resp_vld),
    .l2c_resp_id   (l2c_resp_id),
    .ebiu_resp_vld (ebiu_resp_vld),
    .ebiu_resp_id  (ebiu_resp_id),
    .piu3_resp_vld (piu3_resp_vld),
    .piu3_resp_id  (piu3_resp_id),
    .piu2_resp_vld (piu2_resp_vld),
    .piu2_resp_id  (piu2_resp_id),
    .piu1_resp_vld (piu1_resp_vld),
    .piu1_resp_id  (piu1_resp_id),
    .piu0_resp_vld (piu0_resp_vld),
    .piu0_resp_id  (piu0_resp_id),
    .entry_resp_en (entry_resp_en)
  );

  //==================================================
  // entry array
  //==================================================

  for (genvar i = 0; i < `RESPQ_DEPTH; i++)
  begin : g_entry
    respq_entry u_entry (
      .respqentyclk      (respqentyclk),
      .cpurst_b          (cpurst_b),
      .create_en         (entry_create_en[i]),
      .create_dvm        (create_dvm),
      .create_cmplt_init (create_cmplt_init),
      .resp_en           (entry_resp_en[i]),
      .vld               (entry_vld[i]),
      .dvm               (entry_dvm[i]),
      .pop               (entry_pop[i])
    );
  end

  // popped entries wait here for the consumer
  respq_retire_arb u_retire_arb (
    .respqentyclk (respqentyclk),
    .cpurst_b     (cpurst_b),
    .entry_pop    (entry_pop),
    .entry_dvm    (entry_dvm),
    .retire_rdy   (retire_rdy),
    .retire_pend  (retire_pend),
    .retire_vld   (retire_vld),
    .retire_id    (retire_id),
    .retire_dvm   (retire_dvm)
  );

endmodule

`default_nettype wire

// ==== respq.f ====
+incdir+hdl
hdl/respq_pkg.sv
hdl/respq_entry.sv
hdl/respq_resp_decode.sv
hdl/respq_ctrl.sv
hdl/respq_retire_arb.sv
hdl/respq_top.sv
sim/respq_chk.sv
sim/respq_tb.sv

// ==== sim/respq_chk.sv ====
/*
  bound assertion checks for the response queue
  retire hold under back-pressure, reset state,
  create id never names a valid entry
*/
`timescale 1ns/1ps
`default_nettype none

module respq_chk (
  input logic                   respqentyclk,
  input logic                   cpurst_b,
  input logic                   create_rdy,
  input respq_pkg::entry_id_t   create_id,
  input respq_pkg::entry_mask_t entry_vld,
  input logic                   retire_vld,
  input logic                   retire_rdy,
  input respq_pkg::entry_id_t   retire_id,
  input logic                   retire_dvm
);

  // stalled retire keeps valid, id and dvm
  retire_hold_a : assert property (@(posedge respqentyclk) disable iff (!cpurst_b)
    retire_vld && !retire_rdy |=> retire_vld && $stable(retire_id) && $stable(retire_dvm))
    else $error("retire payload changed while retire_rdy was low");

  // queue starts empty
  rdy_after_reset_a : assert property (@(posedge respqentyclk)
    $rose(cpurst_b) |-> create_rdy)
    else $error("create_rdy low right after reset");

  retire_in_reset_a : assert property (@(posedge respqentyclk)
    !cpurst_b |-> !retire_vld)
    else $error("retire_vld high during reset");

  // offered id must be a free entry
  create_id_free_a : assert property (@(posedge respqentyclk) disable iff (!cpurst_b)
    create_rdy |-> !entry_vld[create_id])
    else $error("create_id points at a valid entry");

endmodule

bind respq_top respq_chk chk0 (
  .respqentyclk (respqentyclk),
  .cpurst_b     (cpurst_b),
  .create_rdy   (create_rdy),
  .create_id    (create_id),
  .entry_vld    (entry_vld),
  .retire_vld   (retire_vld),
  .retire_rdy   (retire_rdy),
  .retire_id    (retire_id),
  .retire_dvm   (retire_dvm)
);

`default_nettype wire

// ==== sim/respq_tb.sv ====
/*
  response queue testbench
  stimulus table applied in a loop, cycle reference model,
  typed compare tasks, watchdog and verdict
*/
`timescale 1ns/1ps
`default_nettype none
`include "respq_config.svh"

module respq_tb;

  localparam int NROWS       = 7;
  localparam int RETIRE_WAIT = 64;

  // init mask, dvm, order seed selector, retire gap, burst count
  typedef struct packed {
    respq_pkg::src_mask_t init;
    logic                 dvm;
    logic [3:0]           sel;
    logic [3:0]           gap;
    logic [4:0]           burst;
  } row_t;

  logic                   respqentyclk;
  logic                   cpurst_b;
  logic                   create_vld;
  logic                   create_dvm;
  respq_pkg::src_mask_t   create_cmplt_init;
  logic                   create_rdy;
  respq_pkg::entry_id_t   create_id;
  logic                   retire_rdy;
  logic                   retire_vld;
  respq_pkg::entry_id_t   retire_id;
  logic                   retire_dvm;
  // bit 5 l2, bit 4 ebiu, bits 3..0 piu3..piu0
  respq_pkg::src_mask_t   rsp_vld;
  respq_pkg::entry_id_t   rsp_id [`RESPQ_SRC_NUM];

  // model state and expected outputs
  respq_pkg::entry_mask_t m_vld;
  respq_pkg::entry_mask_t m_dvm;
  respq_pkg::entry_mask_t m_pend;
  respq_pkg::entry_mask_t m_pdvm;
  respq_pkg::src_mask_t   m_cmp [`RESPQ_DEPTH];
  logic                   m_hold;
  respq_pkg::entry_id_t   m_hold_id;
  respq_pkg::entry_mask_t e_pop;
  logic                   e_rdy;
  logic                   e_rvld;
  logic                   e_rdvm;
  respq_pkg::entry_id_t   e_cid;
  respq_pkg::entry_id_t   e_rid;

  row_t                   rows [NROWS];
  respq_pkg::entry_id_t   row_ids [$];
  logic [31:0]            lcg_state;
  int                     err_cnt;
  int                     other_cnt;

  respq_top dut0 (
    .*,
    .l2c_resp_vld  (rsp_vld[5]),
    .l2c_resp_id   (rsp_id[5]),
    .ebiu_resp_vld (rsp_vld[4]),
    .ebiu_resp_id  (rsp_id[4]),
    .piu3_resp_vld (rsp_vld[3]),
    .piu3_resp_id  (rsp_id[3]),
    .piu2_resp_vld (rsp_vld[2]),
    .piu2_resp_id  (rsp_id[2]),
    .piu1_resp_vld (rsp_vld[1]),
    .piu1_resp_id  (rsp_id[1]),
    .piu0_resp_vld (rsp_vld[0]),
    .piu0_resp_id  (rsp_id[0])
  );

  initial respqentyclk = 1'b0;
  always #10 respqentyclk = ~respqentyclk;

  //==================================================
  // random numbers
  //==================================================

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // value in 0..n-1
  function automatic int rand_pick(input int n);
    lcg_state = lcg_next(lcg_state);
    return int'(lcg_state[30:16]) % n;
  endfunction

  //==================================================
  // reference model
  //==================================================

  task automatic model_eval();
    respq_pkg::entry_mask_t busy;
    respq_pkg::entry_id_t   low;
    busy   = m_vld | m_pend;
    e_rdy  = ~&busy;
    e_rvld = |m_pend;
    e_cid  = '0;
    low    = '0;
    // lowest free and lowest pending
    for (int i = `RESPQ_DEPTH - 1; i >= 0; i--)
    begin
      if (!busy[i])
        e_cid = respq_pkg::entry_id_t'(i);
      if (m_pend[i])
        low = respq_pkg::entry_id_t'(i);
      e_pop[i] = m_vld[i] & (&m_cmp[i]);
    end
    // stalled retire keeps its entry
    e_rid  = m_hold ? m_hold_id : low;
    e_rdvm = m_pdvm[e_rid];
  endtask

  task automatic model_reset();
    m_vld     = '0;
    m_dvm     = '0;
    m_pend    = '0;
    m_pdvm    = '0;
    m_hold    = 1'b0;
    m_hold_id = '0;
    foreach (m_cmp[i])
      m_cmp[i] = '0;
    model_eval();
  endtask

  // one clock edge, inputs as seen before the edge
  task automatic model_step();
    logic                   fire;
    respq_pkg::entry_mask_t clr;
    fire = create_vld & e_rdy;
    clr  = (e_rvld & retire_rdy) ? (respq_pkg::entry_mask_t'(1) << e_rid) : '0;
    for (int i = 0; i < `RESPQ_DEPTH; i++)
    begin
      if (e_pop[i])
        m_pdvm[i] = m_dvm[i];
      if (fire && (e_cid == respq_pkg::entry_id_t'(i)))
      begin
        m_vld[i] = 1'b1;
        m_dvm[i] = create_dvm;
        m_cmp[i] = create_cmplt_init;
      end
      else
      begin
        for (int s = 0; s < `RESPQ_SRC_NUM; s++)
        begin
          if (rsp_vld[s] && (rsp_id[s] == respq_pkg::entry_id_t'(i)))
            m_cmp[i][s] = 1'b1;
        end
        if (e_pop[i])
          m_vld[i] = 1'b0;
      end
    end
    m_pend    = (m_pend & ~clr) | e_pop;
    m_hold    = e_rvld & ~retire_rdy;
    m_hold_id = e_rid;
    model_eval();
  endtask

  always @(posedge respqentyclk)
  begin
    if (cpurst_b !== 1'b1)
      model_reset();
    else
      model_step();
  end

  //==================================================
  // compare tasks
  //==================================================

  task automatic check_entry_id(input string name, input respq_pkg::entry_id_t got,
                                input respq_pkg::entry_id_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_mask(input string name, input respq_pkg::entry_mask_t got,
                            input respq_pkg::entry_mask_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge respqentyclk)
  begin
    if (cpurst_b === 1'b1)
    begin
      check_flag("create_rdy", create_rdy, e_rdy);
      check_entry_id("create_id", create_id, e_cid);
      check_flag("retire_vld", retire_vld, e_rvld);
      if (e_rvld)
      begin
        check_entry_id("retire_id", retire_id, e_rid);
        check_flag("retire_dvm", retire_dvm, e_rdvm);
      end
      check_mask("entry_vld", dut0.entry_vld, m_vld);
      check_mask("retire_pend", dut0.retire_pend, m_pend);
    end
  end

  //==================================================
  // stimulus
  //==================================================

  task automatic create_entry(input respq_pkg::src_mask_t init, input logic dvm,
                              output respq_pkg::entry_id_t id);
    @(negedge respqentyclk);
    while (!e_rdy)
      @(negedge respqentyclk);
    id = e_cid;
    @(posedge respqentyclk);
    create_vld        <= 1'b1;
    create_dvm        <= dvm;
    create_cmplt_init <= init;
    @(posedge respqentyclk);
    create_vld <= 1'b0;
  endtask

  // one pulse per owed responder, shuffled over all row entries
  task automatic send_responses(input respq_pkg::src_mask_t init);
    respq_pkg::entry_id_t pid [$];
    int                   psrc [$];
    respq_pkg::entry_id_t tid;
    int                   tsrc;
    int                   j;
    foreach (row_ids[k])
    begin
      for (int s = 0; s < `RESPQ_SRC_NUM; s++)
      begin
        if (!init[s])
        begin
          pid.push_back(row_ids[k]);
          psrc.push_back(s);
        end
      end
    end
    for (int k = pid.size() - 1; k > 0; k--)
    begin
      j       = rand_pick(k + 1);
      tid     = pid[k];
      tsrc    = psrc[k];
      pid[k]  = pid[j];
      psrc[k] = psrc[j];
      pid[j]  = tid;
      psrc[j] = tsrc;
    end
    foreach (pid[k])
    begin
      @(posedge respqentyclk);
      rsp_vld         <= respq_pkg::src_mask_t'(1) << psrc[k];
      rsp_id[psrc[k]] <= pid[k];
      @(posedge respqentyclk);
      rsp_vld <= '0;
      if (rand_pick(2) == 1)
        @(posedge respqentyclk);
    end
  endtask

  // count handshakes seen ahead of the edge
  task automatic await_retires(input int n, input int idx);
    int got;
    int waited;
    got    = 0;
    waited = 0;
    while ((got < n) && (waited < RETIRE_WAIT))
    begin
      @(negedge respqentyclk);
      if ((retire_vld === 1'b1) && (retire_rdy === 1'b1))
        got++;
      waited++;
    end
    if (got < n)
    begin
      other_cnt++;
      $display("row %0d: only %0d of %0d entries retired in time", idx, got, n);
    end
  endtask

  task automatic run_row(input row_t row, input int idx);
    respq_pkg::entry_id_t id;
    @(posedge respqentyclk);
    retire_rdy <= 1'b0;
    repeat (row.sel)
      lcg_state = lcg_next(lcg_state);
    row_ids.delete();
    repeat (row.burst)
    begin
      create_entry(row.init, row.dvm, id);
      row_ids.push_back(id);
    end
    // full queue refuses an offered create
    if (row.burst == `RESPQ_DEPTH)
    begin
      @(negedge respqentyclk);
      check_flag("create_rdy when full", create_rdy, 1'b0);
      @(posedge respqentyclk);
      create_vld <= 1'b1;
      repeat (3) @(posedge respqentyclk);
      create_vld <= 1'b0;
    end
    send_responses(row.init);
    repeat (row.gap) @(posedge respqentyclk);
    @(posedge respqentyclk);
    retire_rdy <= 1'b1;
    await_retires(row.burst, idx);
  endtask

  //==================================================
  // main sequence and watchdog
  //==================================================

  initial
  begin
    rows[0] = '{6'h3f, 1'b0, 4'd0, 4'd0, 5'd1};
    rows[1] = '{6'h00, 1'b1, 4'd1, 4'd0, 5'd1};
    rows[2] = '{6'h0f, 1'b0, 4'd2, 4'd3, 5'd3};
    rows[3] = '{6'h3f, 1'b1, 4'd3, 4'd4, 5'd4};
    rows[4] = '{6'h35, 1'b1, 4'd4, 4'd2, 5'd8};
    rows[5] = '{6'h00, 1'b0, 4'd5, 4'd1, 5'd2};
    rows[6] = '{6'h2a, 1'b1, 4'd6, 4'd5, 5'd5};
    lcg_state = 32'h995a_1ede;
    err_cnt   = 0;
    other_cnt = 0;
    cpurst_b          <= 1'b0;
    create_vld        <= 1'b0;
    create_dvm        <= 1'b0;
    create_cmplt_init <= '0;
    retire_rdy        <= 1'b0;
    rsp_vld           <= '0;
    foreach (rsp_id[s])
      rsp_id[s] <= '0;
    repeat (5) @(posedge respqentyclk);
    cpurst_b <= 1'b1;
    foreach (rows[r])
      run_row(rows[r], r);
    repeat (4) @(posedge respqentyclk);
    $display("value errors %0d, other failures %0d", err_cnt, other_cnt);
    if ((err_cnt == 0) && (other_cnt == 0))
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // 64 cycles of 20 ns per row
  initial
  begin
    #(NROWS * 64 * 20);
    $display("watchdog expired before all table rows finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
